/* common/ascon_ctrl_pkg.sv */
`default_nettype none

package ascon_ctrl_pkg;

    // control word towards the state register and its muxes
    typedef struct packed {
        logic shift_en;          // serial shift of the state register
        logic write_en;          // parallel load of the state register
        logic shift_type;        // 1 shifts PAR bits, 0 shifts PAR*shares bits
        logic last_cycle;        // final (possibly short) shift of a round
        logic key_load;          // both key registers
        logic sel_init_load;     // iv | key | nonce into the state
        logic sel_x3;            // x3 takes the key xor path
        logic sel_x4;            // x4 takes the key / domain xor path
        logic sel_masked_round;  // masked permutation datapath
        logic sel_padding;       // absorb the padded block
        logic sel_xor;           // xor with key instead of zero
        logic sel_absorb;        // state xor input block
        logic ciphertext_valid;
    } ctrl_word_t;

endpackage

`default_nettype wire

/* common/ascon_defines.svh */
`ifndef ASCON_DEFINES_SVH
`define ASCON_DEFINES_SVH

// ==========================================================
// datapath geometry
// ==========================================================
`define ASCON_PAR          1    // bits per share per cycle
`define ASCON_SHARES       2    // masking order d plus one
`define ASCON_LANE_W       64   // one ascon lane
`define ASCON_BLOCK_BYTES  16   // rate block of the aead mode
`define ASCON_VB_W         5    // valid_bytes counts 0 to 16

// ==========================================================
// shift counts per round kind
// ==========================================================
// masked round walks one share slice at a time
`define ASCON_FULL_SHIFTS  ((`ASCON_LANE_W + `ASCON_PAR - 1) / `ASCON_PAR)
// unmasked round moves all shares in parallel
`define ASCON_SHARE_SHIFTS \
    ((`ASCON_LANE_W + `ASCON_PAR * `ASCON_SHARES - 1) / (`ASCON_PAR * `ASCON_SHARES))
`define ASCON_CNT_W        ($clog2(`ASCON_FULL_SHIFTS + 1))  // holds FULL_SHIFTS

`endif

/* common/ascon_phase_pkg.sv */
`default_nettype none

package ascon_phase_pkg;

    // controller phases in processing order
    typedef enum logic [4:0] {
        ph_idle,               // wait for start
        ph_init_load,          // wait for key, load iv/key/nonce
        ph_init_shift,         // masked round shifting
        ph_init_shift_last,
        ph_init_diffuse,       // round write back
        ph_init_diffuse_last,  // last init round plus key xor
        ph_absorb_ad,          // take ad block or pad block
        ph_ad_shift,           // unmasked round shifting
        ph_ad_shift_last,
        ph_ad_diffuse,
        ph_ad_diffuse_last,    // decides more ad or switch to message
        ph_absorb_msg,         // take message block or pad block
        ph_msg_shift,
        ph_msg_shift_last,
        ph_msg_diffuse,
        ph_msg_diffuse_last,
        ph_fin_shift,          // finalization, masked again
        ph_fin_shift_last,
        ph_fin_diffuse,        // tag out on round 11
        ph_squeeze_tag,
        ph_done                // hold until start drops
    } phase_t;

endpackage

`default_nettype wire

/* common/block_flags_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface block_flags_if;

    logic take_last;    // last ad / message block taken
    logic take_pad;     // extra pad block absorbed
    logic clear_last;
    logic last_done;    // last block of the current stream is in
    logic pad_pending;  // full last block, pad block still owed
    logic short_block;  // valid_bytes below a full block

    modport seq (output take_last, take_pad, clear_last,
                 input  last_done, pad_pending, short_block);

    modport trk (input  take_last, take_pad, clear_last,
                 output last_done, pad_pending, short_block);

endinterface

`default_nettype wire

/* common/step_count_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ascon_defines.svh"

interface step_count_if;

    logic                    shift_en;     // bit counter runs
    logic                    round_en;     // one round written back
    logic                    round_rst;    // force round count to 0
    logic                    masked;       // wrap to 0, else wrap to 4
    logic                    full_shift;   // masked shift limit
    logic [`ASCON_CNT_W-1:0] bit_count;
    logic [3:0]              round_count;
    logic                    shift_done;   // limit of current phase reached
    logic                    round_last;   // round 11

    modport seq (output shift_en, round_en, round_rst, masked, full_shift,
                 input  bit_count, round_count, shift_done, round_last);

    modport cnt (input  shift_en, round_en, round_rst, masked, full_shift,
                 output bit_count, round_count, shift_done, round_last);

endinterface

`default_nettype wire

/* design/ascon_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ascon_defines.svh"

module ascon_ctrl_top import ascon_ctrl_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    start,
    input  wire logic                    key_valid,
    input  wire logic                    valid_data_in,
    input  wire logic                    last_block,
    input  wire logic                    eot,
    input  wire logic [`ASCON_VB_W-1:0]  valid_bytes,
    output logic                         shift_en,
    output logic                         write_en,
    output logic                         shift_type,
    output logic                         last_cycle,
    output logic                         key_load,
    output logic                         sel_init_load,
    output logic                         sel_x3,
    output logic                         sel_x4,
    output logic                         sel_masked_round,
    output logic                         sel_padding,
    output logic                         sel_xor,
    output logic                         sel_absorb,
    output logic                         ciphertext_valid,
    output logic                         ready_for_data,
    output logic                         read_data,
    output logic                         tag_valid,
    output logic                         done,
    output logic [`ASCON_CNT_W-1:0]      bit_count,
    output logic [3:0]                   round_count
);

    ctrl_word_t ctrl;  // packed control word from the sequencer

    step_count_if  cnt_if ();
    block_flags_if flg_if ();

    phase_fsm u_fsm (
        .clk            (clk),
        .reset_n        (reset_n),
        .start          (start),
        .key_valid      (key_valid),
        .valid_data_in  (valid_data_in),
        .last_block     (last_block),
        .eot            (eot),
        .seq            (cnt_if.seq),
        .flags          (flg_if.seq),
        .ctrl           (ctrl),
        .ready_for_data (ready_for_data),
        .read_data      (read_data),
        .tag_valid      (tag_valid),
        .done           (done)
    );

    step_counters u_cnt (
        .clk     (clk),
        .reset_n (reset_n),
        .cnt     (cnt_if.cnt)
    );

    block_tracker u_trk (
        .clk         (clk),
        .reset_n     (reset_n),
        .valid_bytes (valid_bytes),
        .trk         (flg_if.trk)
    );

    // ==========================================================
    // control word onto plain ports
    // ==========================================================
    assign shift_en         = ctrl.shift_en;
    assign write_en         = ctrl.write_en;
    assign shift_type       = ctrl.shift_type;
    assign last_cycle       = ctrl.last_cycle;
    assign key_load         = ctrl.key_load;
    assign sel_init_load    = ctrl.sel_init_load;
    assign sel_x3           = ctrl.sel_x3;
    assign sel_x4           = ctrl.sel_x4;
    assign sel_masked_round = ctrl.sel_masked_round;
    assign sel_padding      = ctrl.sel_padding;
    assign sel_xor          = ctrl.sel_xor;
    assign sel_absorb       = ctrl.sel_absorb;
    assign ciphertext_valid = ctrl.ciphertext_valid;

    assign bit_count   = cnt_if.bit_count;    // exposed for the datapath slice select
    assign round_count = cnt_if.round_count;  // round constant index

endmodule

`default_nettype wire

/* design/block_tracker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ascon_defines.svh"

module block_tracker (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic [`ASCON_VB_W-1:0] valid_bytes,
    block_flags_if.trk                  trk
);

    localparam logic [`ASCON_VB_W-1:0] FULL_BLOCK = `ASCON_BLOCK_BYTES;

    // a short block carries its own padding
    assign trk.short_block = (valid_bytes < FULL_BLOCK);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            trk.last_done   <= 1'b0;
            trk.pad_pending <= 1'b0;
        end else begin
            if (trk.take_last) begin
                trk.last_done   <= 1'b1;
                trk.pad_pending <= ~trk.short_block;  // full block needs a pad block
            end else if (trk.take_pad) begin
                trk.pad_pending <= 1'b0;
            end
            if (trk.clear_last)
                trk.last_done <= 1'b0;  // next stream starts fresh
        end
    end

    // the sequencer only absorbs a pad block that was scheduled here
    a_pad_scheduled: assert property (@(posedge clk) disable iff (!reset_n)
        trk.take_pad |-> trk.pad_pending)
        else $error("pad block absorbed with no pad pending");

endmodule

`default_nettype wire

/* design/phase_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_fsm import ascon_phase_pkg::*, ascon_ctrl_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic start,
    input  wire logic key_valid,
    input  wire logic valid_data_in,
    input  wire logic last_block,
    input  wire logic eot,
    step_count_if.seq seq,
    block_flags_if.seq flags,
    output ctrl_word_t ctrl,
    output logic      ready_for_data,
    output logic      read_data,
    output logic      tag_valid,
    output logic      done
);

    phase_t state, next_state;

    assign seq.masked = ctrl.sel_masked_round;  // wrap mode follows the datapath mode

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= ph_idle;
        else
            state <= next_state;
    end

    // ==========================================================
    // next state and mealy outputs
    // ==========================================================
    always_comb begin
        next_state      = state;
        ctrl            = '0;
        ready_for_data  = 1'b0;
        read_data       = 1'b0;
        tag_valid       = 1'b0;
        done            = 1'b0;
        seq.shift_en    = 1'b0;
        seq.round_en    = 1'b0;
        seq.round_rst   = 1'b0;
        seq.full_shift  = 1'b0;
        flags.take_last = 1'b0;
        flags.take_pad  = 1'b0;
        flags.clear_last = 1'b0;

        case (state)
            ph_idle: if (start) next_state = ph_init_load;

            ph_init_load: begin
                if (key_valid) begin
                    ctrl.key_load      = 1'b1;
                    ctrl.sel_init_load = 1'b1;  // iv | key | nonce
                    ctrl.write_en      = 1'b1;
                    seq.round_rst      = 1'b1;
                    next_state         = ph_init_shift;
                end
            end

            ph_init_shift, ph_fin_shift: begin  // masked shift run
                ctrl.shift_en         = 1'b1;
                ctrl.shift_type       = 1'b1;
                ctrl.sel_masked_round = 1'b1;
                seq.shift_en          = 1'b1;
                seq.full_shift        = 1'b1;
                if (seq.shift_done)
                    next_state = (state == ph_init_shift) ? ph_init_shift_last
                                                          : ph_fin_shift_last;
            end

            ph_init_shift_last: begin
                ctrl.shift_en         = 1'b1;
                ctrl.shift_type       = 1'b1;
                ctrl.last_cycle       = 1'b1;
                ctrl.sel_masked_round = 1'b1;
                next_state = seq.round_last ? ph_init_diffuse_last : ph_init_diffuse;
            end

            ph_init_diffuse: begin
                ctrl.write_en         = 1'b1;
                ctrl.sel_masked_round = 1'b1;
                seq.round_en          = 1'b1;
                next_state            = ph_init_shift;
            end

            ph_init_diffuse_last: begin  // state xor 0*|key, counter wraps to 4
                ctrl.write_en = 1'b1;
                ctrl.sel_x3   = 1'b1;
                ctrl.sel_x4   = 1'b1;
                ctrl.sel_xor  = 1'b1;
                seq.round_en  = 1'b1;
                next_state    = ph_absorb_ad;
            end

            ph_absorb_ad, ph_absorb_msg: begin
                if (flags.pad_pending) begin  // extra pad block, no input read
                    ctrl.write_en    = 1'b1;
                    ctrl.sel_absorb  = 1'b1;
                    ctrl.sel_padding = 1'b1;
                    flags.take_pad   = 1'b1;
                    if (state == ph_absorb_ad) begin
                        next_state = ph_ad_shift;
                    end else begin
                        ctrl.ciphertext_valid = 1'b1;
                        ctrl.sel_init_load    = 1'b1;
                        seq.round_rst         = 1'b1;  // finalization counts 0 to 11
                        next_state            = ph_fin_shift;
                    end
                end else if (valid_data_in) begin
                    read_data       = 1'b1;
                    ctrl.write_en   = 1'b1;
                    ctrl.sel_absorb = 1'b1;
                    if (state == ph_absorb_ad) begin
                        flags.take_last  = last_block;
                        ctrl.sel_padding = last_block & flags.short_block;
                        next_state       = ph_ad_shift;
                    end else begin
                        ctrl.ciphertext_valid = 1'b1;
                        flags.take_last       = eot;
                        next_state            = ph_msg_shift;
                        if (eot && flags.short_block) begin  // padded in place, finalize
                            ctrl.sel_padding   = 1'b1;
                            ctrl.sel_init_load = 1'b1;
                            seq.round_rst      = 1'b1;
                            next_state         = ph_fin_shift;
                        end
                    end
                end else begin
                    read_data      = 1'b1;  // back-pressure, hold here
                    ready_for_data = 1'b1;
                end
            end

            ph_ad_shift, ph_msg_shift: begin  // unmasked shift run
                ctrl.shift_en = 1'b1;
                seq.shift_en  = 1'b1;
                if (seq.shift_done)
                    next_state = (state == ph_ad_shift) ? ph_ad_shift_last : ph_msg_shift_last;
            end

            ph_ad_shift_last: begin
                ctrl.shift_en   = 1'b1;
                ctrl.last_cycle = 1'b1;
                next_state = seq.round_last ? ph_ad_diffuse_last : ph_ad_diffuse;
            end

            ph_msg_shift_last: begin
                ctrl.shift_en   = 1'b1;
                ctrl.last_cycle = 1'b1;
                next_state = seq.round_last ? ph_msg_diffuse_last : ph_msg_diffuse;
            end

            ph_ad_diffuse, ph_msg_diffuse: begin
                ctrl.write_en = 1'b1;
                seq.round_en  = 1'b1;
                next_state = (state == ph_ad_diffuse) ? ph_ad_shift : ph_msg_shift;
            end

            ph_ad_diffuse_last: begin
                ctrl.write_en = 1'b1;
                seq.round_en  = 1'b1;
                next_state    = ph_absorb_ad;
                if (flags.last_done && !flags.pad_pending) begin
                    ctrl.sel_x4      = 1'b1;  // domain separation bit
                    flags.clear_last = 1'b1;
                    next_state       = ph_absorb_msg;
                end
            end

            ph_msg_diffuse_last: begin
                ctrl.write_en = 1'b1;
                seq.round_en  = 1'b1;
                next_state    = ph_absorb_msg;
            end

            ph_fin_shift_last: begin
                ctrl.shift_en         = 1'b1;
                ctrl.shift_type       = 1'b1;
                ctrl.last_cycle       = 1'b1;
                ctrl.sel_masked_round = 1'b1;
                ctrl.sel_x3           = seq.round_last;  // key xor on the final round
                ctrl.sel_x4           = seq.round_last;
                ctrl.sel_xor          = seq.round_last;
                next_state            = ph_fin_diffuse;
            end

            ph_fin_diffuse: begin
                ctrl.write_en         = 1'b1;
                ctrl.sel_masked_round = 1'b1;  // wraps back to 0 after round 11
                seq.round_en          = 1'b1;
                tag_valid             = seq.round_last;
                next_state = seq.round_last ? ph_squeeze_tag : ph_fin_shift;
            end

            ph_squeeze_tag: begin
                flags.clear_last = 1'b1;
                next_state       = ph_done;
            end

            ph_done: begin
                done = 1'b1;
                if (!start) next_state = ph_idle;
            end

            default: next_state = ph_idle;
        endcase
    end

    // serial shift and parallel load share the state register input
    a_shift_write_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(ctrl.shift_en && ctrl.write_en))
        else $error("shift_en and write_en high together");

endmodule

`default_nettype wire

/* design/step_counters.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ascon_defines.svh"

module step_counters (
    input  wire logic   clk,
    input  wire logic   reset_n,
    step_count_if.cnt   cnt
);

    localparam logic [`ASCON_CNT_W-1:0] FULL_LIM  = `ASCON_FULL_SHIFTS;
    localparam logic [`ASCON_CNT_W-1:0] SHARE_LIM = `ASCON_SHARE_SHIFTS - 1;

    logic [`ASCON_CNT_W-1:0] limit;  // last count of this shift phase

    assign limit          = cnt.full_shift ? FULL_LIM : SHARE_LIM;
    assign cnt.shift_done = (cnt.bit_count == limit);
    assign cnt.round_last = (cnt.round_count == 4'd11);

    // ==========================================================
    // bit and round counters
    // ==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt.bit_count   <= '0;
            cnt.round_count <= '0;
        end else begin
            if (cnt.shift_en) begin
                if (cnt.shift_done)
                    cnt.bit_count <= '0;  // ready for the next round
                else
                    cnt.bit_count <= cnt.bit_count + 1'b1;
            end
            if (cnt.round_rst) begin
                cnt.round_count <= '0;
            end else if (cnt.round_en) begin
                if (cnt.round_last)
                    cnt.round_count <= cnt.masked ? 4'd0 : 4'd4;  // 12 or 8 rounds next
                else
                    cnt.round_count <= cnt.round_count + 4'd1;
            end
        end
    end

    // round constant table only has 12 entries
    a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
        cnt.round_count <= 4'd11)
        else $error("round_count out of range: %0d", cnt.round_count);

endmodule

`default_nettype wire

/* dv/ascon_ctrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ascon_defines.svh"

module ascon_ctrl_checker (
    input wire logic clk,
    input wire logic reset_n,
    input wire logic start,
    input wire logic valid_data_in,
    input wire logic shift_en, write_en, shift_type, last_cycle, key_load,
    input wire logic sel_init_load, sel_x3, sel_x4, sel_masked_round, sel_padding,
    input wire logic sel_xor, sel_absorb,
    input wire logic ciphertext_valid, ready_for_data, read_data, tag_valid, done,
    input wire logic [`ASCON_CNT_W-1:0] bit_count,
    input wire logic [3:0] round_count,
    input wire logic [31:0] exp_ad_absorbs, exp_msg_absorbs, exp_ad_pads, exp_msg_pads
);

    localparam int MASKED_RUN   = `ASCON_FULL_SHIFTS + 2;
    localparam int UNMASKED_RUN = `ASCON_SHARE_SHIFTS + 1;

    int   tests_run, tests_failed, err_total, op_errs;
    int   run_len, seg_runs, exp_mround, exp_uround;
    int   ad_absorbs, ct_count, ad_pads, msg_pads, tag_count, xor_count;
    logic run_type, seg_active, seg_masked, in_msg, busy, prev_done, prev_start;

    task automatic report_mismatch(input string what, input int exp, input int act);
        $display("error op%0d %s: expected %0d, actual %0d", tests_run, what, exp, act);
        op_errs++;
        err_total++;
    endtask

    task automatic note_failure(input string what);
        $display("op%0d: %s", tests_run, what);
        op_errs++;
        err_total++;
    endtask

    task automatic print_summary();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_total);
    endtask

    initial begin
        tests_run = 0;
        tests_failed = 0;
        err_total = 0;
        op_errs = 0;
    end

    // ==========================================================
    // monitor, sampled at the rising edge
    // ==========================================================
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run_len = 0;
            seg_runs = 0;
            exp_mround = 0;
            exp_uround = 4;
            ad_absorbs = 0;
            ct_count = 0;
            ad_pads = 0;
            msg_pads = 0;
            tag_count = 0;
            xor_count = 0;
            run_type = 0;
            seg_active = 0;
            seg_masked = 0;
            in_msg = 0;
            busy = 0;
            prev_done = 0;
            prev_start = 0;
        end else begin
            if (!busy) begin  // idle: everything quiet, counters at zero
                if (shift_en || write_en || key_load || ready_for_data || read_data ||
                    ciphertext_valid || tag_valid || done)
                    note_failure("control output active while idle");
                if (bit_count != 0) report_mismatch("idle bit_count", 0, bit_count);
                if (round_count != 0) report_mismatch("idle round_count", 0, round_count);
                if (start) busy = 1;
            end
            // shift runs
            if (shift_en) begin
                if (sel_masked_round != shift_type)  // masked datapath only on masked runs
                    report_mismatch("sel_masked_round in shift run", shift_type,
                                    sel_masked_round);
                if (run_len == 0) run_type = shift_type;
                else if (shift_type != run_type)
                    note_failure("shift_type changed inside a shift run");
                run_len++;
                if (last_cycle) begin
                    if (run_len != (run_type ? MASKED_RUN : UNMASKED_RUN))
                        report_mismatch("shift run length",
                                        run_type ? MASKED_RUN : UNMASKED_RUN, run_len);
                    if (run_type != seg_masked) note_failure("shift run of the wrong kind");
                    if (run_type) begin  // masked rounds count 0 to 11
                        if (round_count != exp_mround)
                            report_mismatch("masked round", exp_mround, round_count);
                        exp_mround = (exp_mround == 11) ? 0 : exp_mround + 1;
                    end else begin  // unmasked rounds count 4 to 11
                        if (round_count != exp_uround)
                            report_mismatch("unmasked round", exp_uround, round_count);
                        exp_uround = (exp_uround == 11) ? 4 : exp_uround + 1;
                    end
                    seg_runs++;
                    run_len = 0;
                end
            end else begin
                if (run_len != 0) note_failure("shift run ended without last_cycle");
                run_len = 0;
                if (last_cycle) note_failure("last_cycle outside a shift run");
            end
            // key xor closes initialization and the last finalization round
            if (sel_xor) begin
                xor_count++;
                if (round_count != 11) report_mismatch("key xor round", 11, round_count);
            end
            // segment boundaries: init load, absorbs, finalization entry
            if (write_en && (sel_absorb || sel_init_load)) begin
                if (seg_active && seg_runs != (seg_masked ? 12 : 8))
                    report_mismatch(seg_masked ? "initialization rounds" : "absorb rounds",
                                    seg_masked ? 12 : 8, seg_runs);
                seg_active = 1;
                seg_masked = sel_init_load;
                seg_runs   = 0;
                if (sel_init_load) exp_mround = 0;
                if (sel_absorb) exp_uround = 4;
            end
            if (key_load) in_msg = 0;
            // back-pressure
            if (ready_for_data) begin
                if (valid_data_in) note_failure("ready_for_data high with data offered");
                if (write_en || shift_en || ciphertext_valid)
                    note_failure("datapath active during back-pressure");
                if (!read_data) note_failure("read_data low while waiting for data");
            end else if (read_data && !valid_data_in) begin
                note_failure("ready_for_data low while waiting for data");
            end
            // absorbs and padding
            if (write_en && sel_absorb) begin
                if (read_data) begin
                    if (!valid_data_in) note_failure("block taken without valid data");
                end else begin
                    if (!sel_padding) note_failure("pad block absorbed without sel_padding");
                    if (in_msg) msg_pads++;
                    else ad_pads++;
                end
                if (!in_msg) ad_absorbs++;
            end
            if (ciphertext_valid) begin
                if (!(in_msg && write_en && sel_absorb))
                    note_failure("ciphertext_valid outside a message absorb");
                ct_count++;
            end
            if (write_en && sel_x4 && !sel_x3) in_msg = 1;  // ad done, domain separation
            // completion
            if (tag_valid) begin
                tag_count++;
                if (seg_runs != 12) report_mismatch("finalization rounds", 12, seg_runs);
                seg_active = 0;
            end
            if (prev_done && prev_start && !done) note_failure("done fell while start high");
            if (prev_done && !prev_start && done)
                note_failure("done still high a cycle after start fell");
            if (done && !prev_done) begin
                if (ad_absorbs != exp_ad_absorbs)
                    report_mismatch("ad absorbs", exp_ad_absorbs, ad_absorbs);
                if (ct_count != exp_msg_absorbs)
                    report_mismatch("ciphertext pulses", exp_msg_absorbs, ct_count);
                if (ad_pads != exp_ad_pads) report_mismatch("ad pad blocks", exp_ad_pads, ad_pads);
                if (msg_pads != exp_msg_pads)
                    report_mismatch("message pad blocks", exp_msg_pads, msg_pads);
                if (tag_count != 1) report_mismatch("tag_valid pulses", 1, tag_count);
                if (xor_count != 2) report_mismatch("key xor pulses", 2, xor_count);
                if (op_errs == 0) $display("test op%0d: ok", tests_run);
                else $display("test op%0d: FAILED with %0d errors", tests_run, op_errs);
                if (op_errs != 0) tests_failed++;
                tests_run++;
                op_errs = 0;
                ad_absorbs = 0;
                ct_count = 0;
                ad_pads = 0;
                msg_pads = 0;
                tag_count = 0;
                xor_count = 0;
            end
            if (busy && done && !start) busy = 0;  // idle from the next cycle
            prev_done  = done;
            prev_start = start;
        end
    end

endmodule

`default_nettype wire

/* dv/ascon_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ascon_defines.svh"

module ascon_ctrl_tb;

    localparam int     NUM_OPS     = 20;
    localparam longint WATCHDOG_NS = 64'd20 * 3000 * 40;  // ops x cycles x period

    logic clk, reset_n, start, key_valid, valid_data_in, last_block, eot;
    logic [`ASCON_VB_W-1:0] valid_bytes;
    logic shift_en, write_en, shift_type, last_cycle, key_load, sel_init_load;
    logic sel_x3, sel_x4, sel_masked_round, sel_padding, sel_xor, sel_absorb;
    logic ciphertext_valid, ready_for_data, read_data, tag_valid, done;
    logic [`ASCON_CNT_W-1:0] bit_count;
    logic [3:0]              round_count;

    logic [31:0] exp_ad_absorbs, exp_msg_absorbs, exp_ad_pads, exp_msg_pads;  // model of one op
    integer seed;

    ascon_ctrl_top ascon_ctrl_i (.*);

    ascon_ctrl_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // ==========================================================
    // stimulus
    // ==========================================================
    // offer one block early, or after the controller has waited a random gap
    task automatic feed_block(input logic is_last_ad, input logic is_eot,
                              input logic [`ASCON_VB_W-1:0] vb);
        int gap;
        gap = {$random(seed)} % 5;
        if (gap != 0) begin
            while (!read_data) @(negedge clk);  // controller waits in an absorb state
            repeat (gap) @(negedge clk);        // back-pressure for gap cycles
        end
        valid_data_in = 1'b1;
        last_block    = is_last_ad;
        eot           = is_eot;
        valid_bytes   = vb;
        @(posedge clk);
        while (!(read_data && valid_data_in)) @(posedge clk);  // take seen at this edge
        @(negedge clk);
        valid_data_in = 1'b0;
        last_block    = 1'b0;
        eot           = 1'b0;
        valid_bytes   = `ASCON_BLOCK_BYTES;
    endtask

    function automatic logic [`ASCON_VB_W-1:0] pick_last_bytes();
        if ({$random(seed)} % 3 == 0)
            return `ASCON_BLOCK_BYTES;  // full last block forces a pad block
        return 1 + {$random(seed)} % 15;
    endfunction

    task automatic run_operation();
        int n_ad, n_msg, key_delay;
        logic [`ASCON_VB_W-1:0] ad_vb, msg_vb;
        n_ad      = 1 + {$random(seed)} % 3;
        n_msg     = 1 + {$random(seed)} % 3;
        key_delay = {$random(seed)} % 4;
        ad_vb     = pick_last_bytes();
        msg_vb    = pick_last_bytes();
        exp_ad_pads     = (ad_vb == `ASCON_BLOCK_BYTES);
        exp_msg_pads    = (msg_vb == `ASCON_BLOCK_BYTES);
        exp_ad_absorbs  = n_ad + exp_ad_pads;
        exp_msg_absorbs = n_msg + exp_msg_pads;
        start = 1'b1;
        repeat (key_delay) @(negedge clk);
        key_valid = 1'b1;
        for (int i = 0; i < n_ad; i++)
            feed_block(i == n_ad - 1, 1'b0,
                       (i == n_ad - 1) ? ad_vb : `ASCON_BLOCK_BYTES);
        for (int i = 0; i < n_msg; i++)
            feed_block(1'b0, i == n_msg - 1,
                       (i == n_msg - 1) ? msg_vb : `ASCON_BLOCK_BYTES);
        @(posedge clk);
        while (!done) @(posedge clk);
        @(negedge clk);
        start     = 1'b0;  // release done
        key_valid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        seed = 18271;
        reset_n = 1'b0;
        start = 1'b0;
        key_valid = 1'b0;
        valid_data_in = 1'b0;
        last_block = 1'b0;
        eot = 1'b0;
        valid_bytes = `ASCON_BLOCK_BYTES;
        exp_ad_absorbs = 0;
        exp_msg_absorbs = 0;
        exp_ad_pads = 0;
        exp_msg_pads = 0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        repeat (3) @(negedge clk);
        for (int op = 0; op < NUM_OPS; op++)
            run_operation();
        repeat (4) @(negedge clk);
        chk.print_summary();
        if (chk.err_total == 0 && chk.tests_failed == 0 && chk.tests_run == NUM_OPS)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, an operation never reached done");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/ascon_phase_pkg.sv
common/ascon_ctrl_pkg.sv
common/step_count_if.sv
common/block_flags_if.sv
design/step_counters.sv
design/block_tracker.sv
design/phase_fsm.sv
design/ascon_ctrl_top.sv
dv/ascon_ctrl_checker.sv
dv/ascon_ctrl_tb.sv
